//--- tft_touch_defs.svh
`ifndef TFT_TOUCH_DEFS_SVH
`define TFT_TOUCH_DEFS_SVH

// panel geometry in tft_clk periods and lines
`define TFT_H_VISIBLE 480
`define TFT_H_TOTAL 525
`define TFT_V_VISIBLE 272
`define TFT_V_TOTAL 286

// cclk cycles per spi bit
`define TOUCH_SPI_DIV 16
// lowest z1 reading taken as a press
`define TOUCH_Z_THRESH 512

// axi4-lite register offsets
`define REG_CTRL 8'h00
`define REG_DUTY 8'h04
`define REG_PERIOD 8'h08
`define REG_COLOR 8'h0C
`define REG_TOUCH 8'h10

// register values after reset
`define RST_DISPLAY_ON 1'b0
`define RST_DUTY 8'd0
`define RST_PERIOD 16'd255
`define RST_COLOR 24'hFFFFFF

// adc control bytes, start bit set, 12-bit differential mode
`define TOUCH_CMD_X 8'hD0
`define TOUCH_CMD_Y 8'h90
`define TOUCH_CMD_Z1 8'hB0

`endif

//--- tft_touch_pkg.sv
package tft_touch_pkg;

	// master side of the host port
	typedef struct packed {
		logic [7:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [7:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	// slave side of the host port
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	// one full x/y/z sweep, valid pulses once per sweep
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		logic [11:0] z;
		logic        valid;
	} touch_sample_t;

	// cursor position in panel pixels
	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
		logic       present;
	} cursor_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		logic        display_on;
		logic [7:0]  duty;
		logic [15:0] period;
		rgb_t        color;
	} tft_cfg_t;

endpackage

//--- touch_spi_ctrl.sv
`timescale 1ns/1ps
`include "tft_touch_defs.svh"

module touch_spi_ctrl (
	input  logic                          cclk,
	input  logic                          rst_n,
	input  logic                          touch_data_out,
	output logic                          touch_clk,
	output logic                          touch_csb,
	output logic                          touch_data_in,
	output tft_touch_pkg::touch_sample_t  sample
);

	localparam int DIV_W = $clog2(`TOUCH_SPI_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`TOUCH_SPI_DIV - 1);
	localparam logic [DIV_W-1:0] DIV_MID = DIV_W'(`TOUCH_SPI_DIV / 2 - 1);
	// bit slots of one 24-bit conversion, slot 24 is the csb-high gap
	localparam logic [4:0] BIT_CMD_LAST = 5'd7;
	localparam logic [4:0] BIT_RES_FIRST = 5'd9;
	localparam logic [4:0] BIT_RES_LAST = 5'd20;
	localparam logic [4:0] BIT_CONV_LAST = 5'd23;
	localparam logic [4:0] BIT_GAP = 5'd24;

	logic [DIV_W-1:0] div_cnt;
	logic [4:0]       bit_cnt;
	logic [1:0]       chan;
	logic [7:0]       cmd;
	logic [7:0]       cmd_sr;
	logic [11:0]      res_sr;
	logic [11:0]      x_q;
	logic [11:0]      y_q;
	logic [11:0]      out_x;
	logic [11:0]      out_y;
	logic [11:0]      out_z;
	logic             out_valid;
	logic             bit_end;
	logic             bit_mid;
	logic             conv_done;

	assign bit_end = (div_cnt == DIV_LAST);
	// touch_clk rises after this cycle
	assign bit_mid = (div_cnt == DIV_MID);
	assign conv_done = bit_end && (bit_cnt == BIT_CONV_LAST);

	// command for the channel about to convert
	always_comb begin
		case (chan)
			2'd0: cmd = `TOUCH_CMD_X;
			2'd1: cmd = `TOUCH_CMD_Y;
			default: cmd = `TOUCH_CMD_Z1;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			bit_cnt <= BIT_GAP;
			chan <= 2'd0;
			touch_csb <= 1'b1;
			touch_clk <= 1'b0;
			touch_data_in <= 1'b0;
			cmd_sr <= '0;
			out_valid <= 1'b0;
		end else begin
			// pulse once z1 is in, x and y already held
			out_valid <= conv_done && (chan == 2'd2);
			div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
			if (bit_mid && bit_cnt != BIT_GAP)
				touch_clk <= 1'b1;
			if (bit_end) begin
				// falling edge, new mosi bit goes out here
				touch_clk <= 1'b0;
				if (bit_cnt == BIT_GAP) begin
					bit_cnt <= 5'd0;
					touch_csb <= 1'b0;
					touch_data_in <= cmd[7];
					cmd_sr <= {cmd[6:0], 1'b0};
				end else if (bit_cnt == BIT_CONV_LAST) begin
					bit_cnt <= BIT_GAP;
					touch_csb <= 1'b1;
					chan <= (chan == 2'd2) ? 2'd0 : chan + 2'd1;
				end else begin
					bit_cnt <= bit_cnt + 5'd1;
					// zeros after the command byte
					touch_data_in <= (bit_cnt < BIT_CMD_LAST) ? cmd_sr[7] : 1'b0;
					cmd_sr <= {cmd_sr[6:0], 1'b0};
				end
			end
		end
	end

	always_ff @(posedge cclk) begin
		// result bits sampled on the rising touch_clk edge
		if (bit_mid && bit_cnt >= BIT_RES_FIRST && bit_cnt <= BIT_RES_LAST)
			res_sr <= {res_sr[10:0], touch_data_out};
		if (conv_done) begin
			case (chan)
				2'd0: x_q <= res_sr;
				2'd1: y_q <= res_sr;
				default: begin
					out_x <= x_q;
					out_y <= y_q;
					out_z <= res_sr;
				end
			endcase
		end
	end

	assign sample.x = out_x;
	assign sample.y = out_y;
	assign sample.z = out_z;
	assign sample.valid = out_valid;

endmodule

//--- touch_cursor.sv
`timescale 1ns/1ps
`include "tft_touch_defs.svh"

module touch_cursor (
	input  logic                          cclk,
	input  logic                          rst_n,
	input  tft_touch_pkg::touch_sample_t  sample,
	input  logic                          new_frame,
	output tft_touch_pkg::cursor_t        cursor
);

	localparam logic [11:0] Z_THRESH = 12'(`TOUCH_Z_THRESH);

	logic [11:0] last_x;
	logic [11:0] last_y;
	logic [11:0] last_z;
	// set once the first sweep has landed
	logic        have_sample;
	logic        pressed;

	always_ff @(posedge cclk) begin
		if (sample.valid) begin
			last_x <= sample.x;
			last_y <= sample.y;
			last_z <= sample.z;
		end
	end

	assign pressed = have_sample && (last_z >= Z_THRESH);

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			have_sample <= 1'b0;
			cursor <= '0;
		end else begin
			if (sample.valid)
				have_sample <= 1'b1;
			// latch once per frame so the crosshair never tears
			if (new_frame) begin
				cursor.present <= pressed;
				if (pressed) begin
					// 12-bit adc scale down by four, top bits dropped
					cursor.x <= last_x[10:2];
					cursor.y <= last_y[10:2];
				end
			end
		end
	end

endmodule

//--- tft_config_regs.sv
`timescale 1ns/1ps
`include "tft_touch_defs.svh"

module tft_config_regs (
	input  logic                      cclk,
	input  logic                      rst_n,
	input  tft_touch_pkg::axil_req_t  axil_req,
	output tft_touch_pkg::axil_rsp_t  axil_rsp,
	input  tft_touch_pkg::cursor_t    cursor,
	output tft_touch_pkg::tft_cfg_t   cfg
);

	logic        aw_rdy;
	logic        b_vld;
	logic        ar_rdy;
	logic        r_vld;
	logic [31:0] r_data;
	logic [1:0]  r_resp;
	logic        wr_go;
	logic        rd_go;
	logic [31:0] rd_word;
	logic        rd_err;

	// address and data together, one write in flight
	assign wr_go = axil_req.awvalid && axil_req.wvalid && !aw_rdy && !b_vld;
	assign rd_go = axil_req.arvalid && !ar_rdy && !r_vld;

	// read decode
	always_comb begin
		rd_word = '0;
		rd_err = 1'b0;
		case (axil_req.araddr)
			`REG_CTRL: rd_word = {31'd0, cfg.display_on};
			`REG_DUTY: rd_word = {24'd0, cfg.duty};
			`REG_PERIOD: rd_word = {16'd0, cfg.period};
			`REG_COLOR: rd_word = {8'd0, cfg.color};
			`REG_TOUCH: rd_word = {cursor.present, 6'd0, cursor.y, 7'd0, cursor.x};
			default: rd_err = 1'b1;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			aw_rdy <= 1'b0;
			b_vld <= 1'b0;
			ar_rdy <= 1'b0;
			r_vld <= 1'b0;
			cfg.display_on <= `RST_DISPLAY_ON;
			cfg.duty <= `RST_DUTY;
			cfg.period <= `RST_PERIOD;
			cfg.color <= `RST_COLOR;
		end else begin
			aw_rdy <= wr_go;
			ar_rdy <= rd_go;
			// response held until the master takes it
			if (aw_rdy)
				b_vld <= 1'b1;
			else if (axil_req.bready)
				b_vld <= 1'b0;
			if (ar_rdy)
				r_vld <= 1'b1;
			else if (axil_req.rready)
				r_vld <= 1'b0;
			// handshake cycle, byte lanes per wstrb
			if (aw_rdy) begin
				case (axil_req.awaddr)
					`REG_CTRL: if (axil_req.wstrb[0]) cfg.display_on <= axil_req.wdata[0];
					`REG_DUTY: if (axil_req.wstrb[0]) cfg.duty <= axil_req.wdata[7:0];
					`REG_PERIOD: begin
						if (axil_req.wstrb[0]) cfg.period[7:0] <= axil_req.wdata[7:0];
						if (axil_req.wstrb[1]) cfg.period[15:8] <= axil_req.wdata[15:8];
					end
					`REG_COLOR: begin
						if (axil_req.wstrb[0]) cfg.color.b <= axil_req.wdata[7:0];
						if (axil_req.wstrb[1]) cfg.color.g <= axil_req.wdata[15:8];
						if (axil_req.wstrb[2]) cfg.color.r <= axil_req.wdata[23:16];
					end
					// touch status and holes take no writes
					default: ;
				endcase
			end
		end
	end

	// read data captured with arready, slverr on holes
	always_ff @(posedge cclk) begin
		if (ar_rdy) begin
			r_data <= rd_word;
			r_resp <= rd_err ? 2'b10 : 2'b00;
		end
	end

	assign axil_rsp.awready = aw_rdy;
	assign axil_rsp.wready = aw_rdy;
	assign axil_rsp.bvalid = b_vld;
	assign axil_rsp.bresp = 2'b00;
	assign axil_rsp.arready = ar_rdy;
	assign axil_rsp.rvalid = r_vld;
	assign axil_rsp.rdata = r_data;
	assign axil_rsp.rresp = r_resp;

endmodule

//--- tft_timing.sv
`timescale 1ns/1ps
`include "tft_touch_defs.svh"

module tft_timing (
	input  logic                      cclk,
	input  logic                      rst_n,
	input  tft_touch_pkg::tft_cfg_t   cfg,
	input  tft_touch_pkg::cursor_t    cursor,
	output logic                      tft_clk,
	output logic                      tft_data_ena,
	output logic                      tft_display,
	output logic                      tft_vdd,
	output logic [7:0]                tft_red,
	output logic [7:0]                tft_green,
	output logic [7:0]                tft_blue,
	output logic                      new_frame
);

	import tft_touch_pkg::*;

	localparam logic [9:0] H_VIS = 10'(`TFT_H_VISIBLE);
	localparam logic [9:0] H_LAST = 10'(`TFT_H_TOTAL - 1);
	localparam logic [8:0] V_VIS = 9'(`TFT_V_VISIBLE);
	localparam logic [8:0] V_LAST = 9'(`TFT_V_TOTAL - 1);

	logic       clk_q;
	logic [9:0] hcnt;
	logic [8:0] vcnt;
	logic       step;
	logic       visible;
	logic       on_cursor;
	rgb_t       pix_nxt;
	rgb_t       pix_q;

	// tft_clk rises at the end of this cycle
	assign step = !clk_q;
	assign visible = (hcnt < H_VIS) && (vcnt < V_VIS);
	// crosshair through the latched touch point
	assign on_cursor = cursor.present && (hcnt == {1'b0, cursor.x} || vcnt == cursor.y);

	always_comb begin
		pix_nxt = '0;
		if (visible && on_cursor)
			pix_nxt = cfg.color;
	end

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			clk_q <= 1'b0;
			hcnt <= '0;
			vcnt <= '0;
			new_frame <= 1'b0;
			tft_data_ena <= 1'b0;
		end else begin
			clk_q <= !clk_q;
			new_frame <= 1'b0;
			if (step) begin
				if (hcnt == H_LAST) begin
					hcnt <= '0;
					if (vcnt == V_LAST) begin
						vcnt <= '0;
						new_frame <= 1'b1;
					end else begin
						vcnt <= vcnt + 9'd1;
					end
				end else begin
					hcnt <= hcnt + 10'd1;
				end
			end else begin
				// outputs move on the falling edge, stable at the panel's rising edge
				tft_data_ena <= cfg.display_on && visible;
			end
		end
	end

	always_ff @(posedge cclk) begin
		if (!step)
			pix_q <= pix_nxt;
	end

	assign tft_clk = clk_q;
	assign tft_display = cfg.display_on;
	assign tft_vdd = cfg.display_on;
	assign tft_red = pix_q.r;
	assign tft_green = pix_q.g;
	assign tft_blue = pix_q.b;

endmodule

//--- backlight_pwm.sv
`timescale 1ns/1ps
`include "tft_touch_defs.svh"

module backlight_pwm (
	input  logic                     cclk,
	input  logic                     rst_n,
	input  tft_touch_pkg::tft_cfg_t  cfg,
	output logic                     tft_backlight
);

	logic [15:0] cnt;
	// shadow copies, reloaded only at wrap
	logic [15:0] per_q;
	logic [7:0]  duty_q;
	logic        wrap;

	// period 0 wraps every cycle
	assign wrap = ({1'b0, cnt} + 17'd1) >= {1'b0, per_q};

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			cnt <= '0;
			per_q <= `RST_PERIOD;
			duty_q <= `RST_DUTY;
			tft_backlight <= 1'b0;
		end else begin
			if (wrap) begin
				cnt <= '0;
				per_q <= cfg.period;
				duty_q <= cfg.duty;
			end else begin
				cnt <= cnt + 16'd1;
			end
			// high for the first duty counts of each period
			tft_backlight <= cnt < {8'd0, duty_q};
		end
	end

endmodule

//--- tft_touch_top.sv
`timescale 1ns/1ps

module tft_touch_top (
	input  logic                      cclk,
	input  logic                      rst_n,
	input  tft_touch_pkg::axil_req_t  axil_req,
	output tft_touch_pkg::axil_rsp_t  axil_rsp,
	output logic                      touch_clk,
	output logic                      touch_csb,
	output logic                      touch_data_in,
	input  logic                      touch_data_out,
	output logic                      tft_backlight,
	output logic                      tft_clk,
	output logic                      tft_data_ena,
	output logic                      tft_display,
	output logic                      tft_vdd,
	output logic [7:0]                tft_red,
	output logic [7:0]                tft_green,
	output logic [7:0]                tft_blue
);

	import tft_touch_pkg::*;

	touch_sample_t sample;
	cursor_t       cursor;
	tft_cfg_t      cfg;
	logic          new_frame;

	// adc sweeps run free
	touch_spi_ctrl touch_i (
		.cclk(cclk),
		.rst_n(rst_n),
		.touch_data_out(touch_data_out),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.sample(sample)
	);

	// per-frame latch to panel pixels
	touch_cursor cursor_i (
		.cclk(cclk),
		.rst_n(rst_n),
		.sample(sample),
		.new_frame(new_frame),
		.cursor(cursor)
	);

	tft_config_regs regs_i (
		.cclk(cclk),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.cursor(cursor),
		.cfg(cfg)
	);

	tft_timing timing_i (
		.cclk(cclk),
		.rst_n(rst_n),
		.cfg(cfg),
		.cursor(cursor),
		.tft_clk(tft_clk),
		.tft_data_ena(tft_data_ena),
		.tft_display(tft_display),
		.tft_vdd(tft_vdd),
		.tft_red(tft_red),
		.tft_green(tft_green),
		.tft_blue(tft_blue),
		.new_frame(new_frame)
	);

	backlight_pwm pwm_i (
		.cclk(cclk),
		.rst_n(rst_n),
		.cfg(cfg),
		.tft_backlight(tft_backlight)
	);

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset held low, released just after a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5 rst_n = 1'b1;
	end

endmodule

//--- tb_touch_adc_model.sv
`timescale 1ns/1ps

module tb_touch_adc_model (
	input  logic        touch_clk,
	input  logic        touch_csb,
	input  logic        touch_data_in,
	output logic        touch_data_out,
	input  logic [11:0] x_val,
	input  logic [11:0] y_val,
	input  logic [11:0] z_val,
	output logic        cmd_error
);

	// rising clock edges seen in this conversion
	logic [4:0]  edges;
	logic [7:0]  cmd;
	logic [11:0] result;

	initial begin
		touch_data_out = 1'b0;
		cmd_error = 1'b0;
		edges = '0;
		cmd = '0;
		result = '0;
	end

	// csb high ends a conversion
	always @(posedge touch_csb)
		edges <= '0;

	always @(posedge touch_clk) begin
		if (!touch_csb) begin
			if (edges < 5'd8)
				cmd <= {cmd[6:0], touch_data_in};
			edges <= edges + 5'd1;
		end
	end

	// output changes after the falling edge
	always @(negedge touch_clk) begin
		if (!touch_csb) begin
			if (edges == 5'd8) begin
				// start bit then channel select a2..a0
				case (cmd[6:4])
					3'b101: result <= x_val;
					3'b001: result <= y_val;
					3'b011: result <= z_val;
					default: cmd_error <= 1'b1;
				endcase
				if (!cmd[7])
					cmd_error <= 1'b1;
				// busy bit slot
				touch_data_out <= 1'b0;
			end else if (edges >= 5'd9 && edges <= 5'd20) begin
				// result msb first
				touch_data_out <= result[5'd20 - edges];
			end else begin
				touch_data_out <= 1'b0;
			end
		end
	end

endmodule

//--- tb_tft_touch.sv
`timescale 1ns/1ps
`include "tft_touch_defs.svh"

module tb_tft_touch;

	import tft_touch_pkg::*;

	// one frame in cclk cycles, pixel clock is cclk / 2
	localparam int FRAME_CYCLES = 2 * `TFT_H_TOTAL * `TFT_V_TOTAL;
	// five frames of scanning and waiting plus margin
	localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 98500;

	logic        clk;
	logic        rst_n;
	axil_req_t   req;
	axil_rsp_t   rsp;
	logic        touch_clk;
	logic        touch_csb;
	logic        touch_data_in;
	logic        touch_data_out;
	logic        tft_backlight;
	logic        tft_clk;
	logic        tft_data_ena;
	logic        tft_display;
	logic        tft_vdd;
	logic [7:0]  tft_red;
	logic [7:0]  tft_green;
	logic [7:0]  tft_blue;
	logic [11:0] adc_x;
	logic [11:0] adc_y;
	logic [11:0] adc_z;
	logic [11:0] z_release;
	logic        adc_cmd_error;
	logic [8:0]  cx;
	logic [8:0]  cy;
	rgb_t        color_exp;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	integer      seed;
	int          highs;
	int          value_errors;
	int          other_errors;
	int          cycle_count;

	tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) clk_gen_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	tb_touch_adc_model adc_i (
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.touch_data_out(touch_data_out),
		.x_val(adc_x),
		.y_val(adc_y),
		.z_val(adc_z),
		.cmd_error(adc_cmd_error)
	);

	tft_touch_top dut_i (
		.cclk(clk),
		.rst_n(rst_n),
		.axil_req(req),
		.axil_rsp(rsp),
		.touch_clk(touch_clk),
		.touch_csb(touch_csb),
		.touch_data_in(touch_data_in),
		.touch_data_out(touch_data_out),
		.tft_backlight(tft_backlight),
		.tft_clk(tft_clk),
		.tft_data_ena(tft_data_ena),
		.tft_display(tft_display),
		.tft_vdd(tft_vdd),
		.tft_red(tft_red),
		.tft_green(tft_green),
		.tft_blue(tft_blue)
	);

	// responses must hold until taken
	bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.bvalid && !req.bready |=> rsp.bvalid)
		else begin
			$display("bvalid dropped before the master took the write response");
			other_errors++;
		end

	rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
		else begin
			$display("rvalid or rdata changed before the master took the read data");
			other_errors++;
		end

	// spi clock idles low between conversions
	spi_clk_idle: assert property (@(posedge clk) disable iff (!rst_n)
		touch_csb |-> !touch_clk)
		else begin
			$display("touch_clk toggled while touch_csb was high");
			other_errors++;
		end

	panel_power: assert property (@(posedge clk) disable iff (!rst_n)
		tft_vdd == tft_display)
		else begin
			$display("tft_vdd and tft_display disagree");
			other_errors++;
		end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
			else begin
				$display("error %s: expected %h, actual %h", name, exp, act);
				value_errors++;
			end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int b_stall);
		@(posedge clk);
		#5;
		req.awaddr = addr;
		req.awvalid = 1'b1;
		req.wdata = data;
		req.wstrb = strb;
		req.wvalid = 1'b1;
		req.bready = (b_stall == 0);
		do @(negedge clk); while (!rsp.awready);
		check_value("write wready", 1'b1, rsp.wready);
		@(posedge clk);
		#5;
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		do @(negedge clk); while (!rsp.bvalid);
		check_value("write resp", 2'b00, rsp.bresp);
		// back-pressure, response has to stay up
		if (b_stall > 0) begin
			repeat (b_stall) begin
				@(negedge clk);
				check_value("bvalid hold", 1'b1, rsp.bvalid);
			end
			@(posedge clk);
			#5;
			req.bready = 1'b1;
		end
		@(posedge clk);
		#5;
		req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr);
		@(posedge clk);
		#5;
		req.araddr = addr;
		req.arvalid = 1'b1;
		req.rready = 1'b0;
		do @(negedge clk); while (!rsp.arready);
		@(posedge clk);
		#5;
		req.arvalid = 1'b0;
		do @(negedge clk); while (!rsp.rvalid);
		rdata = rsp.rdata;
		rresp = rsp.rresp;
		// one cycle of back-pressure before rready
		@(posedge clk);
		#5;
		req.rready = 1'b1;
		@(posedge clk);
		#5;
		req.rready = 1'b0;
	endtask

	task automatic read_expect(input string name, input logic [7:0] addr,
			input logic [31:0] exp, input logic [1:0] exp_resp);
		axi_read(addr);
		check_value(name, exp, rdata);
		check_value({name, " resp"}, exp_resp, rresp);
	endtask

	task automatic count_high(input int span);
		highs = 0;
		repeat (span) begin
			@(negedge clk);
			if (tft_backlight)
				highs++;
		end
	endtask

	// returns on the cycle new_frame is high
	task automatic wait_new_frame();
		do @(negedge clk); while (!dut_i.new_frame);
	endtask

	// one frame, sampled after each tft_clk rising edge
	task automatic scan_frame(input string name, input logic show_cursor);
		int          col;
		int          row;
		logic        lit;
		logic [23:0] pix_exp;
		logic [23:0] pix;
		col = 0;
		row = 0;
		@(negedge clk);
		while (!dut_i.new_frame) begin
			if (tft_clk && tft_data_ena) begin
				// crosshair on the cursor row and column only
				lit = show_cursor && (col == cx || row == cy);
				pix_exp = lit ? color_exp : 24'h0;
				pix = {tft_red, tft_green, tft_blue};
				if (pix !== pix_exp)
					check_value($sformatf("%s pixel %0d,%0d", name, col, row), pix_exp, pix);
				col++;
			end else if (tft_clk && col != 0) begin
				check_value({name, " line length"}, `TFT_H_VISIBLE, col);
				row++;
				col = 0;
			end
			@(negedge clk);
		end
		check_value({name, " line count"}, `TFT_V_VISIBLE, row);
	endtask

	// x and y kept off pixel 0, bit 11 and the low two bits random
	task automatic pick_touch_point();
		logic [31:0] rnd;
		logic [8:0]  px;
		logic [8:0]  py;
		px = 9'(1 + $unsigned($random(seed)) % 479);
		py = 9'(1 + $unsigned($random(seed)) % 271);
		rnd = $random(seed);
		adc_x = {rnd[0], px, rnd[2:1]};
		adc_y = {rnd[3], py, rnd[5:4]};
		adc_z = 12'(600 + $unsigned($random(seed)) % 3496);
		z_release = 12'($unsigned($random(seed)) % 512);
		// adc value over four, kept to 9 bits
		cx = 9'(adc_x >> 2);
		cy = 9'(adc_y >> 2);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		seed = 32'hcf3e7175;
		value_errors = 0;
		other_errors = 0;
		req = '0;
		pick_touch_point();
		wait (rst_n === 1'b1);
		@(negedge clk);

		// reset state
		check_value("reset data enable", 1'b0, tft_data_ena);
		check_value("reset backlight", 1'b0, tft_backlight);
		check_value("reset display", 1'b0, tft_display);
		check_value("reset vdd", 1'b0, tft_vdd);
		check_value("reset bvalid", 1'b0, rsp.bvalid);
		check_value("reset rvalid", 1'b0, rsp.rvalid);
		check_value("reset awready", 1'b0, rsp.awready);
		check_value("reset wready", 1'b0, rsp.wready);
		check_value("reset arready", 1'b0, rsp.arready);
		check_value("reset csb", 1'b1, touch_csb);
		check_value("reset spi clock", 1'b0, touch_clk);
		read_expect("reset ctrl", `REG_CTRL, 32'h0, 2'b00);
		read_expect("reset duty", `REG_DUTY, 32'h0, 2'b00);
		read_expect("reset period", `REG_PERIOD, 32'd255, 2'b00);
		read_expect("reset color", `REG_COLOR, 32'h00FFFFFF, 2'b00);
		read_expect("reset touch", `REG_TOUCH, 32'h0, 2'b00);

		// full and partial strobes
		axi_write(`REG_COLOR, 32'h00123456, 4'hF, 0);
		read_expect("color full", `REG_COLOR, 32'h00123456, 2'b00);
		axi_write(`REG_COLOR, 32'hAABBCCDD, 4'b0010, 0);
		read_expect("color strobe", `REG_COLOR, 32'h0012CC56, 2'b00);
		axi_write(`REG_PERIOD, 32'hFFFF1234, 4'b0010, 0);
		read_expect("period strobe", `REG_PERIOD, 32'h000012FF, 2'b00);
		axi_write(`REG_DUTY, 32'h00000077, 4'b0000, 0);
		read_expect("duty no strobe", `REG_DUTY, 32'h0, 2'b00);
		axi_write(`REG_TOUCH, 32'hFFFFFFFF, 4'hF, 0);
		read_expect("touch read only", `REG_TOUCH, 32'h0, 2'b00);
		read_expect("unmapped read", 8'h14, 32'h0, 2'b10);

		// backlight, duty write also stalls bready
		axi_write(`REG_PERIOD, 32'd40, 4'b0011, 0);
		axi_write(`REG_DUTY, 32'd13, 4'b0001, 6);
		// no high phase until the new duty is loaded at wrap
		do @(negedge clk); while (!tft_backlight);
		count_high(40);
		check_value("backlight duty 13", 13, highs);
		axi_write(`REG_DUTY, 32'd0, 4'b0001, 0);
		repeat (2 * 40) @(negedge clk);
		count_high(2 * 40);
		check_value("backlight duty 0", 0, highs);

		// panel on
		axi_write(`REG_CTRL, 32'h1, 4'b0001, 0);
		check_value("display on", 1'b1, tft_display);
		check_value("vdd on", 1'b1, tft_vdd);
		color_exp = 24'h12CC56;

		// touch press, first sweep long done before the first frame ends
		wait_new_frame();
		wait_new_frame();
		scan_frame("press frame", 1'b1);
		read_expect("touch press", `REG_TOUCH,
			(32'h1 << 31) | (32'(cy) << 16) | 32'(cx), 2'b00);

		// release, cursor clears at the next frame start
		adc_z = z_release;
		wait_new_frame();
		scan_frame("release frame", 1'b0);
		read_expect("touch release", `REG_TOUCH, (32'(cy) << 16) | 32'(cx), 2'b00);

		// panel off
		axi_write(`REG_CTRL, 32'h0, 4'b0001, 0);
		check_value("display off", 1'b0, tft_display);
		check_value("vdd off", 1'b0, tft_vdd);
		repeat (4) @(negedge clk);
		check_value("data enable off", 1'b0, tft_data_ena);
		check_value("adc command", 1'b0, adc_cmd_error);

		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
tft_touch_pkg.sv
touch_spi_ctrl.sv
touch_cursor.sv
tft_config_regs.sv
tft_timing.sv
backlight_pwm.sv
tft_touch_top.sv
tb_clk_gen.sv
tb_touch_adc_model.sv
tb_tft_touch.sv

//--- Bender.yml
package:
  name: tft_touch

sources:
  - include_dirs:
      - .
    files:
      - tft_touch_pkg.sv
      - touch_spi_ctrl.sv
      - touch_cursor.sv
      - tft_config_regs.sv
      - tft_timing.sv
      - backlight_pwm.sv
      - tft_touch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_touch_adc_model.sv
      - tb_tft_touch.sv
